/* rtl/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First fetch address out of reset
`define RESET_VECTOR 32'h0000_1000

// Branch target buffer geometry
// Entry count is a power of two that matches the index width
`define BTB_ENTRIES 16
`define BTB_INDEX_BITS 4

// Fixed instruction step in bytes
`define INSTR_BYTES 32'd4

`endif

/* rtl/fetchPkg.sv */
package fetchPkg;

    // Byte address and instruction word
    typedef logic [31:0] addrT;
    typedef logic [31:0] instrT;

    // 2-bit saturating branch counter
    // 0,1 predict not taken, 2,3 predict taken
    typedef logic [1:0] counterT;

    ////////////////////////////////////////////////////////////
    // IF/ID record, MSB first
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic    valid;
        addrT    instrAddr;
        // Prediction made at fetch time, carried for execute
        addrT    predTarget;
        counterT predCounter;
        logic    predTaken;
        instrT   instr;
    } ifIdT;

endpackage

/* rtl/branchPredictor.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module branchPredictor (
    input  logic              Clk,
    input  logic              rstN,
    input  fetchPkg::addrT    fetchAddr,
    input  logic              updateEn,
    input  fetchPkg::addrT    updateAddr,
    input  logic              updateTaken,
    input  fetchPkg::addrT    updateTarget,
    output logic              predTaken,
    output fetchPkg::addrT    predTarget,
    output fetchPkg::counterT predCounter
);
    import fetchPkg::*;

    localparam int Entries   = `BTB_ENTRIES;
    localparam int IndexBits = `BTB_INDEX_BITS;
    localparam int TagBits   = 32 - IndexBits - 2;

    ////////////////////////////////////////////////////////////
    // Table storage
    ////////////////////////////////////////////////////////////
    logic               entryValid   [Entries];
    logic [TagBits-1:0] entryTag     [Entries];
    addrT               entryTarget  [Entries];
    counterT            entryCounter [Entries];

    logic [IndexBits-1:0] lookIdx;
    logic [TagBits-1:0]   lookTag;
    logic                 lookHit;

    logic [IndexBits-1:0] updIdx;
    logic [TagBits-1:0]   updTag;
    logic                 updHit;
    counterT              oldCounter;
    counterT              newCounter;

    ////////////////////////////////////////////////////////////
    // Lookup for the current fetch address
    ////////////////////////////////////////////////////////////
    assign lookIdx = fetchAddr[IndexBits+1:2];
    assign lookTag = fetchAddr[31:IndexBits+2];
    assign lookHit = entryValid[lookIdx] && (entryTag[lookIdx] == lookTag);

    // Miss reads as weakly not taken, falling through
    assign predCounter = lookHit ? entryCounter[lookIdx] : 2'd1;
    assign predTaken   = lookHit && entryCounter[lookIdx][1];
    assign predTarget  = lookHit ? entryTarget[lookIdx] : fetchAddr + `INSTR_BYTES;

    ////////////////////////////////////////////////////////////
    // Training from execute
    ////////////////////////////////////////////////////////////
    assign updIdx     = updateAddr[IndexBits+1:2];
    assign updTag     = updateAddr[31:IndexBits+2];
    assign updHit     = entryValid[updIdx] && (entryTag[updIdx] == updTag);
    assign oldCounter = entryCounter[updIdx];

    always_comb begin
        if (!updHit) begin
            // Fresh entry starts weak in the observed direction
            newCounter = updateTaken ? 2'd2 : 2'd1;
        end else if (updateTaken) begin
            newCounter = (oldCounter == 2'd3) ? 2'd3 : oldCounter + 2'd1;
        end else begin
            newCounter = (oldCounter == 2'd0) ? 2'd0 : oldCounter - 2'd1;
        end
    end

    // Valid bits and counters
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < Entries; i++) begin
                entryValid[i]   <= 1'b0;
                entryCounter[i] <= 2'd1;
            end
        end else if (updateEn) begin
            entryValid[updIdx]   <= 1'b1;
            entryCounter[updIdx] <= newCounter;
        end
    end

    // Tags and targets
    always_ff @(posedge Clk) begin
        if (updateEn) begin
            entryTag[updIdx]    <= updTag;
            entryTarget[updIdx] <= updateTarget;
        end
    end

endmodule

/* rtl/fetchLogic.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetchLogic (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            pcStall,
    input  logic            redirectEn,
    input  fetchPkg::addrT  redirectAddr,
    input  logic            predTaken,
    input  fetchPkg::addrT  predTarget,
    input  fetchPkg::instrT icacheData,
    input  logic            icacheReady,
    output fetchPkg::addrT  fetchAddr,
    output fetchPkg::addrT  icacheAddr,
    output logic            imiss,
    output fetchPkg::instrT fetchInstr,
    output logic            fetchValid
);
    import fetchPkg::*;

    addrT pcQ;
    addrT nextPc;
    addrT seqPc;

    ////////////////////////////////////////////////////////////
    // Next address selection
    ////////////////////////////////////////////////////////////
    assign seqPc = pcQ + `INSTR_BYTES;

    always_comb begin
        if (redirectEn) begin
            // Execute correction wins over everything
            nextPc = redirectAddr;
        end else if (pcStall || !icacheReady) begin
            // Hazard stall or cache miss, retry same address
            nextPc = pcQ;
        end else if (predTaken) begin
            nextPc = predTarget;
        end else begin
            nextPc = seqPc;
        end
    end

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pcQ <= `RESET_VECTOR;
        end else begin
            pcQ <= nextPc;
        end
    end

    // Same address goes to cache and predictor
    assign fetchAddr  = pcQ;
    assign icacheAddr = pcQ;

    ////////////////////////////////////////////////////////////
    // Cache response
    ////////////////////////////////////////////////////////////
    assign imiss      = !icacheReady;
    assign fetchInstr = icacheData;

    // Word is only usable on a hit that is not being discarded
    assign fetchValid = icacheReady && !redirectEn;

endmodule

/* rtl/ifIdReg.sv */
`timescale 1ns/10ps

module ifIdReg (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           flush,
    input  logic           stall,
    input  fetchPkg::ifIdT in,
    output fetchPkg::ifIdT out
);
    import fetchPkg::*;

    // All-zero record, valid low
    localparam ifIdT Bubble = '0;

    ////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            out <= Bubble;
        end else if (!stall) begin
            out <= in;
        end
        // Stall keeps every field as is
    end

endmodule

/* rtl/fetchStage.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetchStage (
    input  logic              Clk,
    input  logic              rstN,
    // Instruction cache
    output fetchPkg::addrT    icacheAddr,
    input  fetchPkg::instrT   icacheData,
    input  logic              icacheReady,
    output logic              imiss,
    // Execute
    input  logic              redirectEn,
    input  fetchPkg::addrT    redirectAddr,
    input  logic              updateEn,
    input  fetchPkg::addrT    updateAddr,
    input  logic              updateTaken,
    input  fetchPkg::addrT    updateTarget,
    // Hazard unit
    input  logic              pcStall,
    input  logic              ifIdStall,
    input  logic              ifIdFlush,
    // Decode
    output fetchPkg::instrT   instr,
    output fetchPkg::addrT    pc,
    output fetchPkg::addrT    instrAddr,
    output logic              predTaken,
    output fetchPkg::addrT    predTarget,
    output fetchPkg::counterT predCounter,
    output logic              valid
);
    import fetchPkg::*;

    addrT    fetchAddr;
    instrT   fetchInstr;
    logic    fetchValid;
    logic    bpTaken;
    addrT    bpTarget;
    counterT bpCounter;
    ifIdT    ifIdIn;
    ifIdT    ifIdOut;

    fetchLogic fetchLogic0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .pcStall      (pcStall),
        .redirectEn   (redirectEn),
        .redirectAddr (redirectAddr),
        .predTaken    (bpTaken),
        .predTarget   (bpTarget),
        .icacheData   (icacheData),
        .icacheReady  (icacheReady),
        .fetchAddr    (fetchAddr),
        .icacheAddr   (icacheAddr),
        .imiss        (imiss),
        .fetchInstr   (fetchInstr),
        .fetchValid   (fetchValid)
    );

    branchPredictor branchPredictor0 (
        .Clk          (Clk),
        .rstN         (rstN),
        .fetchAddr    (fetchAddr),
        .updateEn     (updateEn),
        .updateAddr   (updateAddr),
        .updateTaken  (updateTaken),
        .updateTarget (updateTarget),
        .predTaken    (bpTaken),
        .predTarget   (bpTarget),
        .predCounter  (bpCounter)
    );

    ////////////////////////////////////////////////////////////
    // Record packing
    ////////////////////////////////////////////////////////////
    always_comb begin
        ifIdIn.valid       = fetchValid;
        ifIdIn.instrAddr   = fetchAddr;
        ifIdIn.predTarget  = bpTarget;
        ifIdIn.predCounter = bpCounter;
        ifIdIn.predTaken   = bpTaken;
        ifIdIn.instr       = fetchInstr;
    end

    // Redirect squashes whatever is being fetched now
    ifIdReg ifIdReg0 (
        .Clk   (Clk),
        .rstN  (rstN),
        .flush (ifIdFlush || redirectEn),
        .stall (ifIdStall),
        .in    (ifIdIn),
        .out   (ifIdOut)
    );

    ////////////////////////////////////////////////////////////
    // Decode side
    ////////////////////////////////////////////////////////////
    assign valid       = ifIdOut.valid;
    assign instrAddr   = ifIdOut.instrAddr;
    assign instr       = ifIdOut.instr;
    assign predTaken   = ifIdOut.predTaken;
    assign predTarget  = ifIdOut.predTarget;
    assign predCounter = ifIdOut.predCounter;

    // Sequential return address of the held instruction
    assign pc = ifIdOut.instrAddr + `INSTR_BYTES;

endmodule

/* tb/icacheModel.sv */
`timescale 1ns/10ps

module icacheModel (
    input  logic        Clk,
    input  logic [31:0] icacheAddr,
    input  logic        readyHigh,
    input  logic        readyLow,
    output logic [31:0] icacheData,
    output logic        icacheReady
);
    // Source of the miss pattern
    integer seed = 32'hd493_58be;
    integer draw;
    logic   randReady = 1'b0;

    // Every word is a function of its full address
    assign icacheData = icacheAddr ^ 32'hA5A5_0000;

    // Roughly three hits in four cycles
    always @(posedge Clk) begin
        draw = $random(seed);
        randReady <= (draw[1:0] != 2'b00);
    end

    // Bench overrides win over the random level
    assign icacheReady = readyHigh || (!readyLow && randReady);

endmodule

/* tb/fetchStageTb.sv */
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetchStageTb;
    import fetchPkg::*;

    localparam int   TimeoutCycles = 300;
    localparam addrT DataMask      = 32'hA5A5_0000;
    localparam addrT BranchAddr    = 32'h0000_3010;
    localparam addrT BranchTarget  = 32'h0000_3400;

    logic    Clk = 1'b0;
    logic    rstN, icacheReady, imiss, redirectEn, updateEn, updateTaken;
    logic    pcStall, ifIdStall, ifIdFlush, predTaken, valid, readyHigh, readyLow;
    addrT    icacheAddr, redirectAddr, updateAddr, updateTarget, pc, instrAddr, predTarget;
    instrT   icacheData, instr;
    counterT predCounter;
    int      takenSeen = 0;
    // Decode address one cycle back
    addrT    prevAddr;

    // Expected PC, expected IF/ID contents and predictor mirror
    addrT                       expPc, expAddr, expTarget;
    logic                       expValid, expHit, expTaken;
    counterT                    expCounter;
    logic                       mirValid   [`BTB_ENTRIES];
    addrT                       mirAddr    [`BTB_ENTRIES];
    addrT                       mirTarget  [`BTB_ENTRIES];
    counterT                    mirCounter [`BTB_ENTRIES];

    fetchStage dut0 (.*);
    icacheModel icache0 (.*);

    always #2 Clk = ~Clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    always @(posedge Clk) begin : refModel
        logic [`BTB_INDEX_BITS-1:0] look;
        logic [`BTB_INDEX_BITS-1:0] upd;
        logic                       hit;
        look = expPc[`BTB_INDEX_BITS+1:2];
        upd  = updateAddr[`BTB_INDEX_BITS+1:2];
        hit  = mirValid[look] && (mirAddr[look] == expPc);
        prevAddr <= instrAddr;
        if (valid && predTaken) begin
            takenSeen <= takenSeen + 1;
        end
        if (!rstN) begin
            expPc    <= `RESET_VECTOR;
            expValid <= 1'b0;
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                mirValid[i]   <= 1'b0;
                mirCounter[i] <= 2'd1;
            end
        end else begin
            // Redirect, then stall or miss, then prediction, then next word
            if (redirectEn) begin
                expPc <= redirectAddr;
            end else if (!pcStall && icacheReady) begin
                expPc <= (hit && mirCounter[look] >= 2'd2) ? mirTarget[look] : expPc + 32'd4;
            end
            if (ifIdFlush || redirectEn) begin
                expValid <= 1'b0;
            end else if (!ifIdStall) begin
                expValid   <= icacheReady;
                expAddr    <= expPc;
                expHit     <= hit;
                expTaken   <= hit && mirCounter[look] >= 2'd2;
                expTarget  <= mirTarget[look];
                expCounter <= hit ? mirCounter[look] : 2'd1;
            end
            // Training lands at the edge, lookups above saw the old entry
            if (updateEn) begin
                mirValid[upd]  <= 1'b1;
                mirAddr[upd]   <= updateAddr;
                mirTarget[upd] <= updateTarget;
                if (!(mirValid[upd] && mirAddr[upd] == updateAddr)) begin
                    mirCounter[upd] <= updateTaken ? 2'd2 : 2'd1;
                end else if (updateTaken && mirCounter[upd] != 2'd3) begin
                    mirCounter[upd] <= mirCounter[upd] + 2'd1;
                end else if (!updateTaken && mirCounter[upd] != 2'd0) begin
                    mirCounter[upd] <= mirCounter[upd] - 2'd1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    assert property (@(posedge Clk) disable iff (!rstN) icacheAddr == expPc)
        else mismatch("icacheAddr", $sampled(icacheAddr), $sampled(expPc));
    assert property (@(posedge Clk) disable iff (!rstN) imiss == !icacheReady)
        else mismatch("imiss", 32'($sampled(imiss)), 32'(!$sampled(icacheReady)));
    assert property (@(posedge Clk) disable iff (!rstN) valid == expValid)
        else mismatch("valid", 32'($sampled(valid)), 32'($sampled(expValid)));
    assert property (@(posedge Clk) disable iff (!rstN) valid |-> instrAddr == expAddr)
        else mismatch("instrAddr", $sampled(instrAddr), $sampled(expAddr));
    assert property (@(posedge Clk) disable iff (!rstN) valid |-> instr == (instrAddr ^ DataMask))
        else mismatch("instr", $sampled(instr), $sampled(instrAddr) ^ DataMask);
    assert property (@(posedge Clk) disable iff (!rstN) valid |-> pc == instrAddr + 32'd4)
        else mismatch("pc", $sampled(pc), $sampled(instrAddr) + 32'd4);
    assert property (@(posedge Clk) disable iff (!rstN) valid |-> predTaken == expTaken)
        else mismatch("predTaken", 32'($sampled(predTaken)), 32'($sampled(expTaken)));
    assert property (@(posedge Clk) disable iff (!rstN) valid |-> predCounter == expCounter)
        else mismatch("predCounter", 32'($sampled(predCounter)), 32'($sampled(expCounter)));
    assert property (@(posedge Clk) disable iff (!rstN)
        valid && expHit |-> predTarget == expTarget)
        else mismatch("predTarget", $sampled(predTarget), $sampled(expTarget));
    // Stalled register keeps the same instruction
    assert property (@(posedge Clk) disable iff (!rstN)
        $past(ifIdStall && !ifIdFlush && !redirectEn) |-> instrAddr == prevAddr)
        else mismatch("held instrAddr", $sampled(instrAddr), $sampled(prevAddr));
    assert property (@(posedge Clk) disable iff (!rstN)
        $past(redirectEn || ifIdFlush) |-> !valid)
        else mismatch("valid after squash", 32'($sampled(valid)), 32'd0);

    task automatic abortRun(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] want);
        abortRun($sformatf("ERROR %s got %h expected %h", name, got, want));
    endtask

    task automatic waitForFetch(addrT addr);
        int count = 0;
        do begin
            @(posedge Clk);
            count++;
        end while (!(valid && instrAddr == addr) && count < TimeoutCycles);
        if (!(valid && instrAddr == addr)) begin
            abortRun($sformatf("Timed out waiting for a valid fetch at address %h", addr));
        end
    endtask

    task automatic pulseRedirect(addrT addr);
        redirectEn   <= 1'b1;
        redirectAddr <= addr;
        @(posedge Clk);
        redirectEn <= 1'b0;
    endtask

    task automatic trainBranch(logic taken);
        updateEn     <= 1'b1;
        updateAddr   <= BranchAddr;
        updateTaken  <= taken;
        updateTarget <= BranchTarget;
        @(posedge Clk);
        updateEn <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        rstN         = 1'b0;
        redirectEn   = 1'b0;
        redirectAddr = '0;
        updateEn     = 1'b0;
        updateAddr   = '0;
        updateTaken  = 1'b0;
        updateTarget = '0;
        pcStall      = 1'b0;
        ifIdStall    = 1'b0;
        ifIdFlush    = 1'b0;
        readyHigh    = 1'b1;
        readyLow     = 1'b0;
        repeat (10) @(posedge Clk);
        rstN <= 1'b1;

        // Straight-line fetch, cache always hits
        waitForFetch(`RESET_VECTOR);
        repeat (20) @(posedge Clk);

        // Random misses, then redirects
        readyHigh <= 1'b0;
        repeat (150) @(posedge Clk);
        pulseRedirect(32'h0000_2000);
        waitForFetch(32'h0000_2000);
        pulseRedirect(32'h0000_2800);
        waitForFetch(32'h0000_2800);
        repeat (40) @(posedge Clk);

        // Strongly taken branch
        trainBranch(1'b1);
        trainBranch(1'b1);
        pulseRedirect(BranchAddr - 32'd8);
        waitForFetch(BranchAddr);
        waitForFetch(BranchTarget);

        // Back to weakly not taken, falls through
        trainBranch(1'b0);
        trainBranch(1'b0);
        pulseRedirect(BranchAddr - 32'd8);
        waitForFetch(BranchAddr);
        waitForFetch(BranchAddr + 32'd4);

        // Hazard stall with hits, then one flush
        readyHigh <= 1'b1;
        repeat (5) @(posedge Clk);
        pcStall   <= 1'b1;
        ifIdStall <= 1'b1;
        repeat (6) @(posedge Clk);
        pcStall   <= 1'b0;
        ifIdStall <= 1'b0;
        repeat (8) @(posedge Clk);
        ifIdFlush <= 1'b1;
        @(posedge Clk);
        ifIdFlush <= 1'b0;
        repeat (5) @(posedge Clk);

        // Forced miss burst, fetch address holds
        readyHigh <= 1'b0;
        readyLow  <= 1'b1;
        repeat (4) @(posedge Clk);
        readyLow  <= 1'b0;
        readyHigh <= 1'b1;
        repeat (20) @(posedge Clk);

        if (takenSeen == 0) begin
            abortRun("No taken prediction ever reached the decode outputs");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/fetchPkg.sv
rtl/branchPredictor.sv
rtl/fetchLogic.sv
rtl/ifIdReg.sv
rtl/fetchStage.sv
tb/icacheModel.sv
tb/fetchStageTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetchStageTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
